// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_slice
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/ex_wb.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module ex_wb (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  logic [`RV_AWIDTH-1:0] rd_addr_i,
    input  logic                  we_i,
    input  logic [`RV_XLEN-1:0]   result_i,
    output logic                  wb_we_o,
    output logic [`RV_AWIDTH-1:0] wb_addr_o,
    output logic [`RV_XLEN-1:0]   wb_data_o
);

    // one strobe per retiring write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= valid_i && we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= rd_addr_i;
        wb_data_o <= result_i;
    end

endmodule

// ==== src/id_ex.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module id_ex (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      valid_i,
    input  logic [`RV_AWIDTH-1:0]     rd_addr_i,
    input  logic [`RV_AWIDTH-1:0]     reg1_addr_i,
    input  logic [`RV_AWIDTH-1:0]     reg2_addr_i,
    input  logic [`RV_XLEN-1:0]       reg1_data_i,
    input  logic [`RV_XLEN-1:0]       reg2_data_i,
    input  logic [`RV_IMM_WIDTH-1:0]  imm_i,
    input  rv_pkg::alu_op_e           alu_op_i,
    input  logic                      use_imm_i,
    input  logic                      we_i,
    input  logic                      wb_we_i,
    input  logic [`RV_AWIDTH-1:0]     wb_addr_i,
    input  logic [`RV_XLEN-1:0]       wb_data_i,
    output logic                      valid_o,
    output logic [`RV_AWIDTH-1:0]     rd_addr_o,
    output logic [`RV_AWIDTH-1:0]     reg1_addr_o,
    output logic [`RV_AWIDTH-1:0]     reg2_addr_o,
    output logic [`RV_XLEN-1:0]       reg1_data_o,
    output logic [`RV_XLEN-1:0]       reg2_data_o,
    output logic [`RV_IMM_WIDTH-1:0]  imm_o,
    output rv_pkg::alu_op_e           alu_op_o,
    output logic                      use_imm_o,
    output logic                      we_o
);

    logic [`RV_XLEN-1:0] reg1_data_byp;
    logic [`RV_XLEN-1:0] reg2_data_byp;

    // write-back in flight this cycle, regfile only sees it after the edge
    assign reg1_data_byp = (wb_we_i && (wb_addr_i == reg1_addr_i)) ? wb_data_i : reg1_data_i;
    assign reg2_data_byp = (wb_we_i && (wb_addr_i == reg2_addr_i)) ? wb_data_i : reg2_data_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= valid_i;
            we_o    <= we_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_o   <= rd_addr_i;
        reg1_addr_o <= reg1_addr_i;
        reg2_addr_o <= reg2_addr_i;
        reg1_data_o <= reg1_data_byp;
        reg2_data_o <= reg2_data_byp;
        imm_o       <= imm_i;
        alu_op_o    <= alu_op_i;
        use_imm_o   <= use_imm_i;
    end

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decoder (
    input  logic                      inst_valid_i,
    input  logic [31:0]               inst_i,
    output logic                      valid_o,
    output logic [`RV_AWIDTH-1:0]     rs1_addr_o,
    output logic [`RV_AWIDTH-1:0]     rs2_addr_o,
    output logic [`RV_AWIDTH-1:0]     rd_addr_o,
    output logic [`RV_IMM_WIDTH-1:0]  imm_o,
    output rv_pkg::alu_op_e           alu_op_o,
    output logic                      use_imm_o,
    output logic                      we_o
);

    rv_pkg::opcode_e              opcode;
    logic [2:0]                   funct3;
    logic                         funct7_b30;
    logic                         sub_en;
    logic                         legal;
    logic [`RV_IMM_WIDTH-1:0]     imm_i_type;
    logic [`RV_IMM_WIDTH-1:0]     imm_u_type;
    rv_pkg::alu_op_e              alu_op_f3;

    assign opcode     = rv_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7_b30 = inst_i[30];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i_type = {{(`RV_IMM_WIDTH-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};

    // bit 30 means sub only for register-register ops
    assign sub_en = funct7_b30 && (opcode == rv_pkg::OPC_OP);

    always_comb begin
        case (funct3)
            3'b000:  alu_op_f3 = sub_en ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_op_f3 = rv_pkg::ALU_SLL;
            3'b010:  alu_op_f3 = rv_pkg::ALU_SLT;
            3'b011:  alu_op_f3 = rv_pkg::ALU_SLTU;
            3'b100:  alu_op_f3 = rv_pkg::ALU_XOR;
            3'b101:  alu_op_f3 = funct7_b30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op_f3 = rv_pkg::ALU_OR;
            default: alu_op_f3 = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        rs1_addr_o = inst_i[19:15];
        rs2_addr_o = '0;
        imm_o      = imm_i_type;
        alu_op_o   = alu_op_f3;
        use_imm_o  = 1'b0;
        legal      = 1'b1;
        case (opcode)
            rv_pkg::OPC_OP: begin
                rs2_addr_o = inst_i[24:20];
            end
            rv_pkg::OPC_OP_IMM: begin
                use_imm_o = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                // x0 + upper immediate
                rs1_addr_o = '0;
                imm_o      = imm_u_type;
                alu_op_o   = rv_pkg::ALU_PASS_B;
                use_imm_o  = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // illegal instructions still flow down the pipe, they just never write
    assign valid_o = inst_valid_i;
    assign we_o    = legal && (rd_addr_o != '0);

endmodule

// ==== src/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// integer datapath width
`define RV_XLEN 32

// register address width, x0..x31
`define RV_AWIDTH 5

// number of architectural registers
`define RV_NREGS 32

// immediate after sign or zero extension
`define RV_IMM_WIDTH 32

`endif

// ==== src/rv_exec_slice.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_exec_slice (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    input  logic [31:0]           inst_i,
    output logic                  wb_valid_o,
    output logic [`RV_AWIDTH-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]   wb_data_o
);

    // decode stage
    logic                     dec_valid;
    logic [`RV_AWIDTH-1:0]    dec_rs1_addr;
    logic [`RV_AWIDTH-1:0]    dec_rs2_addr;
    logic [`RV_AWIDTH-1:0]    dec_rd_addr;
    logic [`RV_IMM_WIDTH-1:0] dec_imm;
    rv_pkg::alu_op_e          dec_alu_op;
    logic                     dec_use_imm;
    logic                     dec_we;
    logic [`RV_XLEN-1:0]      rf_rs1_data;
    logic [`RV_XLEN-1:0]      rf_rs2_data;

    // id_ex outputs
    logic                     ex_valid;
    logic [`RV_AWIDTH-1:0]    ex_rd_addr;
    logic [`RV_AWIDTH-1:0]    ex_reg1_addr;
    logic [`RV_AWIDTH-1:0]    ex_reg2_addr;
    logic [`RV_XLEN-1:0]      ex_reg1_data;
    logic [`RV_XLEN-1:0]      ex_reg2_data;
    logic [`RV_IMM_WIDTH-1:0] ex_imm;
    rv_pkg::alu_op_e          ex_alu_op;
    logic                     ex_use_imm;
    logic                     ex_we;

    // execute to ex_wb
    logic                     alu_valid;
    logic [`RV_AWIDTH-1:0]    alu_rd_addr;
    logic                     alu_we;
    logic [`RV_XLEN-1:0]      alu_result;

    // write-back, shared by regfile, bypass, forward and the top ports
    logic                     wb_we;
    logic [`RV_AWIDTH-1:0]    wb_addr;
    logic [`RV_XLEN-1:0]      wb_data;

    rv_decoder u_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .valid_o      (dec_valid),
        .rs1_addr_o   (dec_rs1_addr),
        .rs2_addr_o   (dec_rs2_addr),
        .rd_addr_o    (dec_rd_addr),
        .imm_o        (dec_imm),
        .alu_op_o     (dec_alu_op),
        .use_imm_o    (dec_use_imm),
        .we_o         (dec_we)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (dec_rs1_addr),
        .rs2_addr_i (dec_rs2_addr),
        .we_i       (wb_we),
        .waddr_i    (wb_addr),
        .wdata_i    (wb_data),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    id_ex u_id_ex (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (dec_valid),
        .rd_addr_i   (dec_rd_addr),
        .reg1_addr_i (dec_rs1_addr),
        .reg2_addr_i (dec_rs2_addr),
        .reg1_data_i (rf_rs1_data),
        .reg2_data_i (rf_rs2_data),
        .imm_i       (dec_imm),
        .alu_op_i    (dec_alu_op),
        .use_imm_i   (dec_use_imm),
        .we_i        (dec_we),
        .wb_we_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .valid_o     (ex_valid),
        .rd_addr_o   (ex_rd_addr),
        .reg1_addr_o (ex_reg1_addr),
        .reg2_addr_o (ex_reg2_addr),
        .reg1_data_o (ex_reg1_data),
        .reg2_data_o (ex_reg2_data),
        .imm_o       (ex_imm),
        .alu_op_o    (ex_alu_op),
        .use_imm_o   (ex_use_imm),
        .we_o        (ex_we)
    );

    rv_execute u_execute (
        .valid_i     (ex_valid),
        .rd_addr_i   (ex_rd_addr),
        .reg1_addr_i (ex_reg1_addr),
        .reg2_addr_i (ex_reg2_addr),
        .reg1_data_i (ex_reg1_data),
        .reg2_data_i (ex_reg2_data),
        .imm_i       (ex_imm),
        .alu_op_i    (ex_alu_op),
        .use_imm_i   (ex_use_imm),
        .we_i        (ex_we),
        .fwd_we_i    (wb_we),
        .fwd_addr_i  (wb_addr),
        .fwd_data_i  (wb_data),
        .valid_o     (alu_valid),
        .rd_addr_o   (alu_rd_addr),
        .we_o        (alu_we),
        .result_o    (alu_result)
    );

    ex_wb u_ex_wb (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (alu_valid),
        .rd_addr_i (alu_rd_addr),
        .we_i      (alu_we),
        .result_i  (alu_result),
        .wb_we_o   (wb_we),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    assign wb_valid_o = wb_we;
    assign wb_rd_o    = wb_addr;
    assign wb_data_o  = wb_data;

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute (
    input  logic                      valid_i,
    input  logic [`RV_AWIDTH-1:0]     rd_addr_i,
    input  logic [`RV_AWIDTH-1:0]     reg1_addr_i,
    input  logic [`RV_AWIDTH-1:0]     reg2_addr_i,
    input  logic [`RV_XLEN-1:0]       reg1_data_i,
    input  logic [`RV_XLEN-1:0]       reg2_data_i,
    input  logic [`RV_IMM_WIDTH-1:0]  imm_i,
    input  rv_pkg::alu_op_e           alu_op_i,
    input  logic                      use_imm_i,
    input  logic                      we_i,
    input  logic                      fwd_we_i,
    input  logic [`RV_AWIDTH-1:0]     fwd_addr_i,
    input  logic [`RV_XLEN-1:0]       fwd_data_i,
    output logic                      valid_o,
    output logic [`RV_AWIDTH-1:0]     rd_addr_o,
    output logic                      we_o,
    output logic [`RV_XLEN-1:0]       result_o
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] reg2_fwd;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;

    // forward from the instruction one ahead, now sitting in ex_wb
    assign op_a     = (fwd_we_i && (fwd_addr_i == reg1_addr_i)) ? fwd_data_i : reg1_data_i;
    assign reg2_fwd = (fwd_we_i && (fwd_addr_i == reg2_addr_i)) ? fwd_data_i : reg2_data_i;
    assign op_b     = use_imm_i ? imm_i : reg2_fwd;
    assign shamt    = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:    result_o = op_a + op_b;
            rv_pkg::ALU_SUB:    result_o = op_a - op_b;
            rv_pkg::ALU_SLL:    result_o = op_a << shamt;
            rv_pkg::ALU_SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   result_o = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:    result_o = op_a ^ op_b;
            rv_pkg::ALU_SRL:    result_o = op_a >> shamt;
            rv_pkg::ALU_SRA:    result_o = $signed(op_a) >>> shamt;
            rv_pkg::ALU_OR:     result_o = op_a | op_b;
            rv_pkg::ALU_AND:    result_o = op_a & op_b;
            rv_pkg::ALU_PASS_B: result_o = op_b;
            default:            result_o = '0;
        endcase
    end

    assign valid_o   = valid_i;
    assign rd_addr_o = rd_addr_i;
    assign we_o      = we_i;

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the supported subset
    // anything else decodes as illegal
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // operand b straight through, used by lui
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [`RV_AWIDTH-1:0] rs1_addr_i,
    input  logic [`RV_AWIDTH-1:0] rs2_addr_i,
    input  logic                  we_i,
    input  logic [`RV_AWIDTH-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]   wdata_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // x0 never written, so it reads zero forever
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, same-cycle write not visible here
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// ==== test/tb_rv_exec_slice.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_exec_slice;

    // 6 tests of at most about 60 cycles each plus margin
    localparam int MAX_CYCLES = 600;

    logic                  clk = 1'b0;
    logic                  arst_n_i;
    logic                  inst_valid_i;
    logic [31:0]           inst_i;
    logic                  wb_valid_o;
    logic [`RV_AWIDTH-1:0] wb_rd_o;
    logic [`RV_XLEN-1:0]   wb_data_o;

    logic [`RV_XLEN-1:0]   ref_regs [`RV_NREGS];
    logic [`RV_AWIDTH-1:0] exp_rd [$];
    logic [`RV_XLEN-1:0]   exp_data [$];
    int                    exp_cyc [$];
    int                    want_cyc;
    int                    cycle = 0;
    int                    errors = 0;
    int                    err_start = 0;
    int                    n_checks = 0;
    int                    n_tests = 0;
    integer                seed = 32'hbe90;
    string                 cur_test = "reset";
    // {funct7 bit 30, funct3} of the ten register-register ops
    logic [3:0]            op_tab [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                           4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

    rv_exec_slice DUT (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] op_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] op_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] op_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    task automatic check_rd(input logic [`RV_AWIDTH-1:0] want, input logic [`RV_AWIDTH-1:0] got);
        n_checks++;
        if (want !== got) begin
            $display("Mismatch %s rd expected x%0d actual x%0d", cur_test, want, got);
            errors++;
        end
    endtask

    task automatic check_data(input logic [`RV_XLEN-1:0] want, input logic [`RV_XLEN-1:0] got);
        n_checks++;
        if (want !== got) begin
            $display("Mismatch %s data expected %h actual %h", cur_test, want, got);
            errors++;
        end
    endtask

    // rv32i semantics of the supported ops
    // results retire in program order
    task automatic model_step(input logic [31:0] inst);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        is_op;
        logic        legal;
        rd    = inst[11:7];
        a     = ref_regs[inst[19:15]];
        b     = {{20{inst[31]}}, inst[31:20]};
        is_op = (inst[6:0] == rv_pkg::OPC_OP);
        legal = is_op || (inst[6:0] == rv_pkg::OPC_OP_IMM) || (inst[6:0] == rv_pkg::OPC_LUI);
        if (is_op) begin
            b = ref_regs[inst[24:20]];
        end
        case (inst[14:12])
            3'd0: res = (is_op && inst[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (inst[30]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (inst[6:0] == rv_pkg::OPC_LUI) begin
            res = {inst[31:12], 12'b0};
        end
        if (legal && (rd != 5'd0)) begin
            ref_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            exp_cyc.push_back(cycle + 3);
        end
    endtask

    task automatic issue(input logic [31:0] inst);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        model_step(inst);
    endtask

    task automatic gap(input int n);
        repeat (n) begin
            @(posedge clk);
            inst_valid_i <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_start = errors;
        n_tests++;
    endtask

    // drain until every expected write-back has been seen
    // then idle long enough for a stray strobe to show up
    task automatic finish_test();
        gap(1);
        while (exp_rd.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("%s done, %0d errors", cur_test, errors - err_start);
    endtask

    // write-back monitor on the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (arst_n_i && wb_valid_o) begin
            if (exp_rd.size() == 0) begin
                $display("%s: write-back to x%0d with no write pending", cur_test, wb_rd_o);
                errors++;
            end else begin
                check_rd(exp_rd.pop_front(), wb_rd_o);
                check_data(exp_data.pop_front(), wb_data_o);
                want_cyc = exp_cyc.pop_front();
                if (want_cyc != cycle) begin
                    $display("Mismatch %s latency expected cycle %0d actual %0d",
                             cur_test, want_cyc, cycle);
                    errors++;
                end
            end
        end
    end

    task automatic test_reset_state();
        start_test("test_reset_state");
        // no strobe expected while the pipe is idle
        repeat (10) @(posedge clk);
        issue(op_r(7'h00, 5'd7, 5'd5, 3'd0, 5'd1));
        finish_test();
    endtask

    task automatic test_lui_imm();
        logic [31:0] r;
        logic [31:0] inst;
        start_test("test_lui_imm");
        for (int k = 0; k < 10; k++) begin
            r = $random(seed);
            case (k)
                0: inst = op_lui(r[31:12], 5'd2);
                1: inst = op_i(r[11:0], 5'd2, 3'd0, 5'd3);
                2: inst = op_i(r[11:0], 5'd2, 3'd4, 5'd4);
                3: inst = op_i(r[11:0], 5'd2, 3'd6, 5'd5);
                4: inst = op_i(r[11:0], 5'd2, 3'd7, 5'd6);
                5: inst = op_i(r[11:0], 5'd2, 3'd2, 5'd7);
                6: inst = op_i(r[11:0], 5'd2, 3'd3, 5'd8);
                7: inst = op_i({7'h00, r[4:0]}, 5'd2, 3'd1, 5'd9);
                8: inst = op_i({7'h00, r[4:0]}, 5'd2, 3'd5, 5'd10);
                default: inst = op_i({7'h20, r[4:0]}, 5'd2, 3'd5, 5'd11);
            endcase
            issue(inst);
            gap(2);
        end
        finish_test();
    endtask

    task automatic test_reg_ops();
        logic [31:0] r;
        start_test("test_reg_ops");
        // x5 negative and x6 random
        r = $random(seed);
        issue(op_lui({1'b1, r[30:12]}, 5'd5));
        issue(op_i(r[11:0], 5'd5, 3'd0, 5'd5));
        r = $random(seed);
        issue(op_lui(r[31:12], 5'd6));
        issue(op_i(r[11:0], 5'd6, 3'd0, 5'd6));
        gap(3);
        for (int k = 0; k < 10; k++) begin
            issue(op_r({1'b0, op_tab[k][3], 5'b0}, 5'd6, 5'd5, op_tab[k][2:0], 5'(k + 12)));
            gap(1);
        end
        finish_test();
    endtask

    task automatic test_forwarding();
        logic [31:0] r;
        logic [4:0]  src;
        start_test("test_forwarding");
        r = $random(seed);
        issue(op_lui(r[31:12], 5'd1));
        issue(op_i(r[11:0], 5'd1, 3'd0, 5'd1));
        // chains at distance 1, 2 and 3 issued every cycle
        for (int d = 1; d <= 3; d++) begin
            gap(3);
            for (int i = 0; i < 6; i++) begin
                src = (i < d) ? 5'd1 : 5'(16 + i - d);
                r = $random(seed);
                if (i % 2 == 0) begin
                    issue(op_i(r[11:0], src, 3'd0, 5'(16 + i)));
                end else begin
                    issue(op_r(7'h20, src, 5'd1, 3'd0, 5'(16 + i)));
                end
            end
        end
        finish_test();
    endtask

    task automatic test_x0_and_illegal();
        logic [31:0] r;
        start_test("test_x0_and_illegal");
        r = $random(seed);
        issue(op_lui(r[31:12], 5'd7));
        issue(op_lui(r[19:0], 5'd8));
        gap(3);
        issue(op_i(12'h005, 5'd7, 3'd0, 5'd0));
        issue(op_r(7'h00, 5'd8, 5'd7, 3'd0, 5'd0));
        // load and all-ones opcodes are outside the subset
        issue({r[31:12], 5'd7, 7'b0000011});
        issue({r[31:12], 5'd8, 7'b1111111});
        issue(op_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
        issue(op_i(12'h000, 5'd7, 3'd0, 5'd10));
        issue(op_i(12'h000, 5'd8, 3'd0, 5'd11));
        finish_test();
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        start_test("test_random_stream");
        for (int i = 0; i < 40; i++) begin
            r   = $random(seed);
            rd  = {2'b0, r[2:0]};
            f3  = r[11:9];
            imm = r[31:20];
            if (r[13:12] == 2'd0) begin
                issue(op_lui(r[31:12], rd));
            end else if (!r[13]) begin
                // shifts keep the upper immediate bits legal
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    imm[11:5] = {1'b0, r[30], 5'b0};
                end
                issue(op_i(imm, {2'b0, r[5:3]}, f3, rd));
            end else begin
                issue(op_r(((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, r[30], 5'b0} : 7'h00,
                           {2'b0, r[8:6]}, {2'b0, r[5:3]}, f3, rd));
            end
            if (r[31]) begin
                gap(r[14] ? 2 : 1);
            end
        end
        finish_test();
    endtask

    initial begin
        inst_valid_i = 1'b0;
        inst_i       = '0;
        arst_n_i     = 1'b0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        test_reset_state();
        test_lui_imm();
        test_reg_ops();
        test_forwarding();
        test_x0_and_illegal();
        test_random_stream();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("timeout in %s after %0d cycles", cur_test, cycle);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/id_ex.sv
src/rv_execute.sv
src/ex_wb.sv
src/rv_exec_slice.sv
test/tb_rv_exec_slice.sv
